/* Bender.yml */
package:
  name: link_top

sources:
  - verilog/mem_layout_pkg.sv
  - verilog/link_pkg.sv
  - verilog/apb_link_regs.sv
  - verilog/word_serializer.sv
  - verilog/word_deserializer.sv
  - verilog/record_merge.sv
  - verilog/link_top.sv
  - target: simulation
    files:
      - verification/tb_clock_gen.sv
      - verification/link_top_chk.sv
      - verification/link_top_tb.sv

/* build.f */
verilog/mem_layout_pkg.sv
verilog/link_pkg.sv
verilog/apb_link_regs.sv
verilog/word_serializer.sv
verilog/word_deserializer.sv
verilog/record_merge.sv
verilog/link_top.sv
verification/tb_clock_gen.sv
verification/link_top_chk.sv
verification/link_top_tb.sv

/* verification/link_top_chk.sv */
`default_nettype none
`timescale 1ns/1ps

module link_top_chk (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [link_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input logic pready,
	input logic start,
	input link_pkg::beat_t addr_link,
	input link_pkg::beat_t data_link,
	input logic rec_valid
);

	int unsigned fail_count = 0;
	logic reset_q;
	logic in_flight;

	always_ff @(posedge clk)
		reset_q <= reset; // second reset cycle onward.

	// record in flight from the start pulse until it leaves the merge stage.
	always_ff @(posedge clk) begin
		if (reset)
			in_flight <= 1'b0;
		else if (rec_valid)
			in_flight <= 1'b0;
		else if (start)
			in_flight <= 1'b1;
	end

	assert property (@(posedge clk) disable iff (reset)
		start |-> addr_link.valid [*4] ##1 !addr_link.valid)
	else begin
		$error("address lane did not send four consecutive beats after start");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset)
		start |-> data_link.valid [*3] ##1 !data_link.valid)
	else begin
		$error("data lane did not send three consecutive beats after start");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset)
		start |-> ##3 addr_link.last ##0 $past(data_link.last))
	else begin
		$error("last flag missing on the final beat of a lane");
		fail_count++;
	end

	// record leaves the merge stage five edges after the start pulse.
	assert property (@(posedge clk) disable iff (reset)
		start |-> ##5 rec_valid)
	else begin
		$error("record did not arrive at the expected cycle after start");
		fail_count++;
	end

	assert property (@(posedge clk) disable iff (reset)
		psel && penable && !pready
		|-> pwrite && paddr == link_pkg::REG_DATA && (start || in_flight))
	else begin
		$error("pready low outside a data write while a record was in flight");
		fail_count++;
	end

	assert property (@(posedge clk)
		reset && reset_q |-> !addr_link.valid && !data_link.valid)
	else begin
		$error("link beat valid during reset");
		fail_count++;
	end

endmodule

bind link_top link_top_chk lane_chk (
	.clk(clk),
	.reset(reset),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.paddr(paddr),
	.pready(pready),
	.start(start),
	.addr_link(addr_link),
	.data_link(data_link),
	.rec_valid(rec_valid)
);

`default_nettype wire

/* verification/link_top_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module link_top_tb;

	localparam int APB_TIMEOUT = 32;
	localparam int POLL_TIMEOUT = 32;

	logic clk;
	logic reset;
	logic psel;
	logic penable;
	logic pwrite;
	link_pkg::reg_addr_t paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	logic [31:0] lfsr = 32'hab96_74cb;
	int unsigned edge_count = 0;
	int unsigned checks = 0;
	int unsigned errors = 0;
	int unsigned test_checks;
	int unsigned test_errors;
	logic last_err;
	int unsigned last_edge;
	int unsigned last_stall;

	tb_clock_gen clock_gen (.clk(clk), .reset(reset));

	link_top UUT (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	always @(posedge clk)
		edge_count <= edge_count + 1;

	// x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] value;
		logic fb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			value = {value[30:0], fb};
		end
		return value;
	endfunction

	function automatic logic [3:0] expected_id(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - mem_layout_pkg::WINDOW_BASE;
		if (addr < mem_layout_pkg::WINDOW_BASE)
			return mem_layout_pkg::INVALID_ID;
		if (offset / mem_layout_pkg::REGION_SIZE >= mem_layout_pkg::REGION_COUNT)
			return mem_layout_pkg::INVALID_ID;
		return 4'(offset / mem_layout_pkg::REGION_SIZE);
	endfunction

	task automatic abort_run(input string reason);
		$display("%s at %0t ns", reason, $time);
		$display("Test FAILED");
		$finish;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		test_checks++;
		assert (got === expected)
		else begin
			$display("FAIL %0t ns %s got %h expected %h", $time, name, got, expected);
			test_errors++;
		end
	endtask

	// entered and left 1 ns after a rising edge.
	task automatic apb_access(input logic write, input link_pkg::reg_addr_t addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1 penable = 1'b1;
		last_stall = 0;
		@(negedge clk);
		while (!pready && last_stall < APB_TIMEOUT) begin
			last_stall++;
			@(negedge clk);
		end
		if (!pready)
			abort_run("APB transfer never completed, pready stayed low");
		rdata = prdata;
		last_err = pslverr;
		last_edge = edge_count + 1; // transfer completes at the next edge.
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input link_pkg::reg_addr_t addr, input logic [31:0] wdata);
		logic [31:0] unused;
		apb_access(1'b1, addr, wdata, unused);
	endtask

	task automatic apb_read(input link_pkg::reg_addr_t addr, output logic [31:0] rdata);
		apb_access(1'b0, addr, 32'h0, rdata);
	endtask

	task automatic send_record(input logic [31:0] addr, input logic [31:0] data);
		apb_write(link_pkg::REG_ADDR, addr);
		apb_write(link_pkg::REG_DATA, data);
	endtask

	task automatic wait_status(input int bit_index, input logic value);
		logic [31:0] status;
		int unsigned polls;
		polls = 0;
		apb_read(link_pkg::REG_STATUS, status);
		while (status[bit_index] !== value && polls < POLL_TIMEOUT) begin
			polls++;
			apb_read(link_pkg::REG_STATUS, status);
		end
		if (status[bit_index] !== value)
			abort_run("STATUS bit never reached the expected value");
	endtask

	task automatic begin_test();
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		checks += test_checks;
		errors += test_errors;
	endtask

	initial begin
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] data2;
		logic [31:0] value;
		logic [31:0] addr_list[$];
		int unsigned write_edge;
		int unsigned waited;
		int unsigned chk_fails;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		waited = 0;
		@(posedge clk);
		while (reset !== 1'b0 && waited < 16) begin
			waited++;
			@(posedge clk);
		end
		if (reset !== 1'b0)
			abort_run("reset was never released");
		#1;

		begin_test();
		apb_read(link_pkg::REG_STATUS, value);
		check_value("STATUS", value, 32'h0);
		end_test("reset");

		begin_test();
		for (int i = 0; i < 16; i++) begin
			addr = mem_layout_pkg::WINDOW_BASE + random_bits(15);
			data = random_bits(24);
			send_record(addr, data);
			wait_status(link_pkg::STATUS_VALID_BIT, 1'b1);
			apb_read(link_pkg::REG_RESULT_DATA, value);
			check_value("RESULT_DATA", value, data);
		end
		end_test("round_trip");

		begin_test();
		addr_list = {32'h0000_0000, 32'h3fff_ffff, 32'h4000_8000, 32'hffff_ffff};
		for (int r = 0; r < mem_layout_pkg::REGION_COUNT; r++) begin
			addr_list.push_back(mem_layout_pkg::WINDOW_BASE + r * mem_layout_pkg::REGION_SIZE);
			addr_list.push_back(mem_layout_pkg::WINDOW_BASE
				+ (r + 1) * mem_layout_pkg::REGION_SIZE - 1); // last byte of region.
		end
		foreach (addr_list[i]) begin
			send_record(addr_list[i], random_bits(24));
			wait_status(link_pkg::STATUS_VALID_BIT, 1'b1);
			apb_read(link_pkg::REG_RESULT_ID, value);
			check_value("RESULT_ID", value, 32'(expected_id(addr_list[i])));
			apb_read(link_pkg::REG_RESULT_DATA, value);
		end
		end_test("id_map");

		// one idle cycle shifts the polls onto the odd cycles.
		begin_test();
		for (int gap = 0; gap < 2; gap++) begin
			send_record(mem_layout_pkg::WINDOW_BASE, random_bits(24));
			write_edge = last_edge;
			if (gap != 0) begin
				@(posedge clk);
				#1;
			end
			do begin
				apb_read(link_pkg::REG_STATUS, value);
				check_value("STATUS.valid", value[0], last_edge - write_edge >= 7);
			end while (last_edge - write_edge < 7);
			apb_read(link_pkg::REG_RESULT_DATA, value);
		end
		end_test("latency");

		begin_test();
		addr = mem_layout_pkg::WINDOW_BASE + 32'h2000;
		data = random_bits(24);
		data2 = random_bits(24);
		send_record(addr, data);
		apb_write(link_pkg::REG_DATA, data2);
		check_value("pready stall", last_stall != 0, 1);
		apb_read(link_pkg::REG_RESULT_DATA, value);
		check_value("RESULT_DATA", value, data);
		wait_status(link_pkg::STATUS_VALID_BIT, 1'b1);
		apb_read(link_pkg::REG_RESULT_ID, value);
		check_value("RESULT_ID", value, 32'(expected_id(addr)));
		apb_read(link_pkg::REG_RESULT_DATA, value);
		check_value("RESULT_DATA", value, data2);
		apb_read(link_pkg::REG_STATUS, value);
		check_value("STATUS", value, 32'h0);
		end_test("back_pressure");

		begin_test();
		data = random_bits(24);
		data2 = random_bits(24);
		send_record(mem_layout_pkg::WINDOW_BASE, data);
		wait_status(link_pkg::STATUS_VALID_BIT, 1'b1);
		apb_write(link_pkg::REG_DATA, data2);
		wait_status(link_pkg::STATUS_BUSY_BIT, 1'b0);
		apb_read(link_pkg::REG_STATUS, value);
		check_value("STATUS", value, 32'h5);
		apb_read(link_pkg::REG_RESULT_DATA, value);
		check_value("RESULT_DATA", value, data2);
		apb_read(link_pkg::REG_STATUS, value);
		check_value("STATUS", value, 32'h4);
		apb_write(link_pkg::REG_STATUS, 32'h4);
		apb_read(link_pkg::REG_STATUS, value);
		check_value("STATUS", value, 32'h0);
		end_test("overflow");

		begin_test();
		apb_read(5'h14, value);
		check_value("pslverr", last_err, 1);
		apb_write(link_pkg::REG_RESULT_ID, 32'h3);
		check_value("pslverr", last_err, 1);
		apb_read(link_pkg::REG_STATUS, value);
		check_value("pslverr", last_err, 0);
		end_test("slave_error");

		chk_fails = UUT.lane_chk.fail_count;
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors, chk_fails);
		if (errors == 0 && chk_fails == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic reset
);

	localparam int HALF_PERIOD = 4; // 8 ns clock.
	localparam int RESET_CYCLES = 2;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1 reset = 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/apb_link_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module apb_link_regs (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [link_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input logic [link_pkg::APB_DATA_WIDTH-1:0] pwdata,
	output logic [link_pkg::APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output mem_layout_pkg::addr_t addr_word,
	output link_pkg::data_t data_word,
	output logic start,
	input logic busy,
	input link_pkg::record_t rec,
	input logic rec_valid
);

	logic mapped;
	logic read_only;
	logic done;
	logic wr_done;
	logic rd_data_done;
	logic result_valid;
	logic overflow;
	link_pkg::record_t result;

	always_comb begin
		mapped = 1'b1;
		read_only = 1'b0;
		case (paddr)
			link_pkg::REG_ADDR, link_pkg::REG_DATA, link_pkg::REG_STATUS: read_only = 1'b0;
			link_pkg::REG_RESULT_ID, link_pkg::REG_RESULT_DATA: read_only = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	// a data write waits here until both lanes and the merge stage are idle.
	assign pready = !(psel && pwrite && paddr == link_pkg::REG_DATA && busy);
	assign pslverr = psel && penable && (!mapped || (pwrite && read_only));

	assign done = psel && penable && pready;
	assign wr_done = done && pwrite;
	assign rd_data_done = done && !pwrite && paddr == link_pkg::REG_RESULT_DATA;

	always_ff @(posedge clk) begin
		if (reset) begin
			start <= 1'b0;
			result_valid <= 1'b0;
			overflow <= 1'b0;
		end else begin
			start <= wr_done && paddr == link_pkg::REG_DATA;
			if (rec_valid)
				result_valid <= 1'b1;
			else if (rd_data_done)
				result_valid <= 1'b0;
			if (rec_valid && result_valid && !rd_data_done)
				overflow <= 1'b1; // unread result overwritten.
			else if (wr_done && paddr == link_pkg::REG_STATUS)
				overflow <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_done && paddr == link_pkg::REG_ADDR)
			addr_word <= pwdata;
		if (wr_done && paddr == link_pkg::REG_DATA)
			data_word <= pwdata[link_pkg::DATA_WIDTH-1:0];
		if (rec_valid)
			result <= rec;
	end

	always_comb begin
		prdata = '0;
		case (paddr)
			link_pkg::REG_STATUS: begin
				prdata[link_pkg::STATUS_VALID_BIT] = result_valid;
				prdata[link_pkg::STATUS_BUSY_BIT] = busy;
				prdata[link_pkg::STATUS_OVERFLOW_BIT] = overflow;
			end
			link_pkg::REG_RESULT_ID: prdata[$bits(result.id)-1:0] = result.id;
			link_pkg::REG_RESULT_DATA: prdata[$bits(result.data)-1:0] = result.data;
			default: prdata = '0; // write-only and unmapped read as zero.
		endcase
	end

endmodule

`default_nettype wire

/* verilog/link_pkg.sv */
`default_nettype none

package link_pkg;

	localparam int BUS_WIDTH = 8;
	localparam int DATA_WIDTH = 24;
	localparam int APB_ADDR_WIDTH = 5;
	localparam int APB_DATA_WIDTH = 32;

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [BUS_WIDTH-1:0] chunk_t;
	typedef logic [APB_ADDR_WIDTH-1:0] reg_addr_t;

	typedef struct packed {
		logic valid;
		logic last; // final beat of a word.
		chunk_t chunk;
	} beat_t;

	typedef struct packed {
		mem_layout_pkg::region_id_t id;
		data_t data;
	} record_t;

	localparam reg_addr_t REG_ADDR = 5'h00;
	localparam reg_addr_t REG_DATA = 5'h04; // write starts a send.
	localparam reg_addr_t REG_STATUS = 5'h08;
	localparam reg_addr_t REG_RESULT_ID = 5'h0c;
	localparam reg_addr_t REG_RESULT_DATA = 5'h10;

	localparam int STATUS_VALID_BIT = 0;
	localparam int STATUS_BUSY_BIT = 1;
	localparam int STATUS_OVERFLOW_BIT = 2;

endpackage

`default_nettype wire

/* verilog/link_top.sv */
`default_nettype none
`timescale 1ns/1ps

module link_top (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [link_pkg::APB_ADDR_WIDTH-1:0] paddr,
	input logic [link_pkg::APB_DATA_WIDTH-1:0] pwdata,
	output logic [link_pkg::APB_DATA_WIDTH-1:0] prdata,
	output logic pready,
	output logic pslverr
);

	mem_layout_pkg::addr_t addr_word;
	mem_layout_pkg::addr_t addr_rx;
	link_pkg::data_t data_word;
	link_pkg::data_t data_rx;
	link_pkg::beat_t addr_link;
	link_pkg::beat_t data_link;
	link_pkg::record_t rec;
	logic start;
	logic busy;
	logic addr_busy;
	logic data_busy;
	logic addr_rx_valid;
	logic data_rx_valid;
	logic rec_valid;
	logic pending;

	assign busy = addr_busy || data_busy || pending;

	apb_link_regs regs (
		.clk(clk), .reset(reset),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.addr_word(addr_word), .data_word(data_word), .start(start),
		.busy(busy), .rec(rec), .rec_valid(rec_valid)
	);

	word_serializer #(.payload_t(mem_layout_pkg::addr_t)) addr_ser (
		.clk(clk), .reset(reset), .start(start),
		.word(addr_word), .link(addr_link), .busy(addr_busy)
	);

	word_serializer #(.payload_t(link_pkg::data_t)) data_ser (
		.clk(clk), .reset(reset), .start(start),
		.word(data_word), .link(data_link), .busy(data_busy)
	);

	word_deserializer #(.payload_t(mem_layout_pkg::addr_t)) addr_des (
		.clk(clk), .reset(reset), .link(addr_link),
		.word(addr_rx), .word_valid(addr_rx_valid)
	);

	word_deserializer #(.payload_t(link_pkg::data_t)) data_des (
		.clk(clk), .reset(reset), .link(data_link),
		.word(data_rx), .word_valid(data_rx_valid)
	);

	record_merge merge (
		.clk(clk), .reset(reset),
		.addr_word(addr_rx), .addr_valid(addr_rx_valid),
		.data_word(data_rx), .data_valid(data_rx_valid),
		.rec(rec), .rec_valid(rec_valid), .pending(pending)
	);

endmodule

`default_nettype wire

/* verilog/mem_layout_pkg.sv */
`default_nettype none

package mem_layout_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int ID_WIDTH = 4;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [ID_WIDTH-1:0] region_id_t;

	localparam addr_t WINDOW_BASE = 32'h4000_0000;
	localparam addr_t REGION_SIZE = 32'h0000_1000; // 4 KiB.
	localparam int REGION_COUNT = 8;
	localparam addr_t WINDOW_SIZE = REGION_SIZE * REGION_COUNT;
	localparam int REGION_SHIFT = $clog2(REGION_SIZE);
	localparam region_id_t INVALID_ID = 4'hf;

	function automatic region_id_t addr_to_id(input addr_t addr);
		addr_t offset;
		offset = addr - WINDOW_BASE;
		if (addr < WINDOW_BASE || offset >= WINDOW_SIZE)
			return INVALID_ID;
		return region_id_t'(offset >> REGION_SHIFT); // region index inside the window.
	endfunction

endpackage

`default_nettype wire

/* verilog/record_merge.sv */
`default_nettype none
`timescale 1ns/1ps

module record_merge (
	input logic clk,
	input logic reset,
	input mem_layout_pkg::addr_t addr_word,
	input logic addr_valid,
	input link_pkg::data_t data_word,
	input logic data_valid,
	output link_pkg::record_t rec,
	output logic rec_valid,
	output logic pending
);

	mem_layout_pkg::addr_t addr_hold;
	mem_layout_pkg::addr_t addr_sel;
	link_pkg::data_t data_hold;
	link_pkg::data_t data_sel;
	logic addr_flag;
	logic data_flag;
	logic addr_have;
	logic data_have;

	assign addr_have = addr_flag || addr_valid;
	assign data_have = data_flag || data_valid;
	assign addr_sel = addr_valid ? addr_word : addr_hold; // fresh word bypasses the hold reg.
	assign data_sel = data_valid ? data_word : data_hold;

	always_ff @(posedge clk) begin
		if (reset) begin
			addr_flag <= 1'b0;
			data_flag <= 1'b0;
			rec_valid <= 1'b0;
		end else begin
			rec_valid <= addr_have && data_have;
			addr_flag <= addr_have && !data_have;
			data_flag <= data_have && !addr_have;
		end
	end

	always_ff @(posedge clk) begin
		if (addr_valid)
			addr_hold <= addr_word;
		if (data_valid)
			data_hold <= data_word;
		if (addr_have && data_have) begin
			rec.id <= mem_layout_pkg::addr_to_id(addr_sel);
			rec.data <= data_sel;
		end
	end

	// anything still inside the merge stage counts.
	assign pending = addr_flag || data_flag || addr_valid || data_valid || rec_valid;

endmodule

`default_nettype wire

/* verilog/word_deserializer.sv */
`default_nettype none
`timescale 1ns/1ps

module word_deserializer #(
	parameter type payload_t = link_pkg::data_t
) (
	input logic clk,
	input logic reset,
	input link_pkg::beat_t link,
	output payload_t word,
	output logic word_valid
);

	localparam int WORD_WIDTH = $bits(payload_t);
	localparam int BEATS = (WORD_WIDTH + link_pkg::BUS_WIDTH - 1) / link_pkg::BUS_WIDTH;
	localparam int PAD_WIDTH = BEATS * link_pkg::BUS_WIDTH;
	localparam int CNT_WIDTH = $clog2(BEATS + 1);

	logic [PAD_WIDTH-1:0] assembled;
	logic [PAD_WIDTH-1:0] filled;
	logic [CNT_WIDTH-1:0] count;

	always_comb begin
		filled = assembled;
		filled[count * link_pkg::BUS_WIDTH +: link_pkg::BUS_WIDTH] = link.chunk;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= link.valid && link.last;
			if (link.valid)
				count <= link.last ? '0 : count + 1'b1; // restart after the final beat.
		end
	end

	always_ff @(posedge clk) begin
		if (link.valid)
			assembled <= filled;
		if (link.valid && link.last)
			word <= filled[WORD_WIDTH-1:0];
	end

endmodule

`default_nettype wire

/* verilog/word_serializer.sv */
`default_nettype none
`timescale 1ns/1ps

module word_serializer #(
	parameter type payload_t = link_pkg::data_t
) (
	input logic clk,
	input logic reset,
	input logic start,
	input payload_t word,
	output link_pkg::beat_t link,
	output logic busy
);

	localparam int WORD_WIDTH = $bits(payload_t);
	localparam int BEATS = (WORD_WIDTH + link_pkg::BUS_WIDTH - 1) / link_pkg::BUS_WIDTH;
	localparam int PAD_WIDTH = BEATS * link_pkg::BUS_WIDTH;
	localparam int CNT_WIDTH = $clog2(BEATS + 1);

	logic [PAD_WIDTH-1:0] padded;
	logic [PAD_WIDTH-1:0] shreg;
	logic [CNT_WIDTH-1:0] remaining;

	assign padded = PAD_WIDTH'(word);

	always_ff @(posedge clk) begin
		if (reset)
			remaining <= '0;
		else if (start)
			remaining <= CNT_WIDTH'(BEATS - 1);
		else if (remaining != '0)
			remaining <= remaining - 1'b1;
	end

	always_ff @(posedge clk) begin
		if (start)
			shreg <= padded >> link_pkg::BUS_WIDTH; // low chunk already sent.
		else if (remaining != '0)
			shreg <= shreg >> link_pkg::BUS_WIDTH;
	end

	// first beat leaves in the start cycle, the rest come from the shift register.
	always_comb begin
		link.valid = start || remaining != '0;
		if (start) begin
			link.chunk = padded[link_pkg::BUS_WIDTH-1:0];
			link.last = (BEATS == 1);
		end else begin
			link.chunk = shreg[link_pkg::BUS_WIDTH-1:0];
			link.last = (remaining == CNT_WIDTH'(1));
		end
	end

	assign busy = start || remaining != '0;

endmodule

`default_nettype wire
